// ==== cartPkg.sv ====
package cartPkg;

	// Display and entry code, 0-9 plus a few letters.
	typedef logic [3:0] digitT;

	// Four digitT nibbles, first entered digit in the top nibble.
	typedef logic [15:0] itemCodeT;

	typedef logic [3:0] amountT;
	typedef logic [2:0] unitCountT;
	typedef logic [2:0] typeCountT;
	typedef logic [9:0] priceT;
	typedef logic [15:0] totalT;

	// Active low, bit 0 is segment a.
	typedef logic [6:0] segT;

	typedef enum logic [1:0] {
		modeBlank = 2'b00,
		modeShowTotal = 2'b01,
		modeAdd = 2'b10,
		modeRemove = 2'b11
	} modeT;

	typedef enum logic [2:0] {
		enterDigit3,
		enterDigit2,
		enterDigit1,
		enterDigit0,
		enterAmount,
		readyCommit
	} entryStateT;

	localparam int numItems = 12;

	// Barcodes as BCD nibbles.
	localparam itemCodeT itemCodes [numItems] = '{
		16'h3124, 16'h4132, 16'h4133, 16'h3121, 16'h3133, 16'h3214,
		16'h1111, 16'h2222, 16'h3333, 16'h4444, 16'h1122, 16'h3344
	};

	// Unit prices in kurus.
	localparam priceT itemPrices [numItems] = '{
		10'd250, 10'd50, 10'd75, 10'd200, 10'd100, 10'd995,
		10'd450, 10'd300, 10'd400, 10'd600, 10'd500, 10'd150
	};

	localparam typeCountT maxTypesInCart = 3'd6;
	localparam unitCountT maxUnitsPerType = 3'd4;

	localparam digitT codeA = 4'hA;
	localparam digitT codeBlank = 4'hB;
	localparam digitT codeD = 4'hD;
	localparam digitT codeE = 4'hE;

endpackage

// ==== sevenSegDecoder.sv ====
module sevenSegDecoder (
	input cartPkg::digitT code,
	output cartPkg::segT segments
);
	import cartPkg::*;

	// Patterns read g down to a, zero lights a segment.
	always_comb begin
		case (code)
			4'h0: segments = 7'b1000000;
			4'h1: segments = 7'b1111001;
			4'h2: segments = 7'b0100100;
			4'h3: segments = 7'b0110000;
			4'h4: segments = 7'b0011001;
			4'h5: segments = 7'b0010010;
			4'h6: segments = 7'b0000010;
			4'h7: segments = 7'b1111000;
			4'h8: segments = 7'b0000000;
			4'h9: segments = 7'b0010000;
			codeA: segments = 7'b0001000;
			codeD: segments = 7'b0100001;
			codeE: segments = 7'b0000110;
			default: segments = 7'b1111111;
		endcase
	end

endmodule

// ==== keyEntry.sv ====
module keyEntry (
	input logic clk,
	input logic rstN,
	input logic entryEnable,
	input cartPkg::modeT mode,
	input logic [3:0] buttonsN,
	output logic addStrobe,
	output logic removeStrobe,
	output cartPkg::itemCodeT entryCode,
	output cartPkg::amountT entryAmount,
	output cartPkg::itemCodeT shownDigits,
	output cartPkg::amountT shownAmount
);
	import cartPkg::*;

	entryStateT state;
	itemCodeT workCode;
	amountT workAmount;
	logic pressedLast;
	logic anyPressed;
	logic accept;
	logic clearHeld;
	logic commit;
	digitT keyDigit;

	assign anyPressed = ~&buttonsN;
	assign accept = anyPressed && !pressedLast && entryEnable
		&& (mode == modeAdd || mode == modeRemove);
	assign clearHeld = !buttonsN[2] && !buttonsN[3];
	assign commit = accept && (state == readyCommit);

	// Lowest button number wins.
	assign keyDigit = !buttonsN[0] ? digitT'(4'd4) :
		!buttonsN[1] ? digitT'(4'd3) :
		!buttonsN[2] ? digitT'(4'd2) : digitT'(4'd1);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= enterDigit3;
			pressedLast <= 1'b0;
			addStrobe <= 1'b0;
			removeStrobe <= 1'b0;
			workCode <= {4{codeBlank}};
			workAmount <= '0;
			shownDigits <= {4{codeBlank}};
			shownAmount <= '0;
		end else begin
			pressedLast <= anyPressed;
			addStrobe <= 1'b0;
			removeStrobe <= 1'b0;
			if (accept) begin
				case (state)
					enterDigit3: begin
						workCode[15:12] <= keyDigit;
						shownDigits[15:12] <= keyDigit;
						state <= enterDigit2;
					end
					enterDigit2: begin
						workCode[11:8] <= keyDigit;
						shownDigits[11:8] <= keyDigit;
						state <= enterDigit1;
					end
					enterDigit1: begin
						workCode[7:4] <= keyDigit;
						shownDigits[7:4] <= keyDigit;
						state <= enterDigit0;
					end
					enterDigit0: begin
						workCode[3:0] <= keyDigit;
						shownDigits[3:0] <= keyDigit;
						// Remove takes no amount.
						state <= (mode == modeAdd) ? enterAmount : readyCommit;
					end
					enterAmount: begin
						workAmount <= keyDigit;
						shownAmount <= keyDigit;
						state <= readyCommit;
					end
					default: begin
						addStrobe <= (mode == modeAdd);
						removeStrobe <= (mode == modeRemove);
						workCode <= {4{codeBlank}};
						workAmount <= '0;
						state <= enterDigit3;
					end
				endcase
			end else if (clearHeld) begin
				workCode <= {4{codeBlank}};
				workAmount <= '0;
				shownDigits <= {4{codeBlank}};
				shownAmount <= '0;
				state <= enterDigit3;
			end
		end
	end

	// Held for the strobe cycle and after it.
	always_ff @(posedge clk) begin
		if (commit) begin
			entryCode <= workCode;
			entryAmount <= workAmount;
		end
	end

	// A commit returns to the first digit, so a strobe lasts one cycle.
	assert property (@(posedge clk) disable iff (!rstN)
		(addStrobe || removeStrobe) |=> !(addStrobe || removeStrobe));

endmodule

// ==== cartStore.sv ====
module cartStore (
	input logic clk,
	input logic rstN,
	input logic addStrobe,
	input logic removeStrobe,
	input cartPkg::itemCodeT entryCode,
	input cartPkg::amountT entryAmount,
	output cartPkg::totalT cartTotal,
	output logic opOk
);
	import cartPkg::*;

	unitCountT unitCount [numItems];
	typeCountT typeCount;

	logic hit;
	int hitIdx;
	unitCountT curCount;
	priceT curPrice;
	logic [4:0] sumCount;
	totalT addCost;
	totalT removeCost;
	logic addOk;
	logic removeOk;

	// Catalog lookup.
	always_comb begin
		hit = 1'b0;
		hitIdx = 0;
		for (int i = 0; i < numItems; i++) begin
			if (entryCode == itemCodes[i]) begin
				hit = 1'b1;
				hitIdx = i;
			end
		end
	end

	assign curCount = unitCount[hitIdx];
	assign curPrice = itemPrices[hitIdx];
	assign sumCount = 5'(curCount) + 5'(entryAmount);
	assign addCost = totalT'(entryAmount) * totalT'(curPrice);
	assign removeCost = totalT'(curCount) * totalT'(curPrice);

	// A zero amount would open a type slot with no units, so it is refused.
	assign addOk = hit
		&& (entryAmount != '0)
		&& (typeCount < maxTypesInCart)
		&& (sumCount <= 5'(maxUnitsPerType));

	assign removeOk = hit && (curCount != '0);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numItems; i++) begin
				unitCount[i] <= '0;
			end
			typeCount <= '0;
			cartTotal <= '0;
			opOk <= 1'b0;
		end else if (addStrobe) begin
			opOk <= addOk;
			if (addOk) begin
				unitCount[hitIdx] <= unitCountT'(sumCount);
				cartTotal <= cartTotal + addCost;
				if (curCount == '0) begin
					typeCount <= typeCount + 3'd1;
				end
			end
		end else if (removeStrobe) begin
			opOk <= removeOk;
			if (removeOk) begin
				unitCount[hitIdx] <= '0;
				cartTotal <= cartTotal - removeCost;
				typeCount <= typeCount - 3'd1;
			end
		end
	end

	for (genvar g = 0; g < numItems; g++) begin : gUnitLimit
		assert property (@(posedge clk) disable iff (!rstN)
			unitCount[g] <= maxUnitsPerType);
	end

	assert property (@(posedge clk) disable iff (!rstN) typeCount <= maxTypesInCart);

endmodule

// ==== cartDisplay.sv ====
module cartDisplay (
	input cartPkg::modeT mode,
	input cartPkg::itemCodeT shownDigits,
	input cartPkg::amountT shownAmount,
	input cartPkg::totalT cartTotal,
	output cartPkg::digitT [5:0] codes
);
	import cartPkg::*;

	digitT [5:0] dec;
	logic promptOn;

	// Decimal digits of the total, least significant first.
	always_comb begin
		dec[0] = digitT'(cartTotal % 10);
		dec[1] = digitT'((cartTotal / 10) % 10);
		dec[2] = digitT'((cartTotal / 100) % 10);
		dec[3] = digitT'((cartTotal / 1000) % 10);
		dec[4] = digitT'((cartTotal / 10000) % 10);
		dec[5] = digitT'((cartTotal / 100000) % 10);
	end

	// Nothing entered yet since reset or clear.
	assign promptOn = (shownDigits[15:12] == codeBlank);

	always_comb begin
		codes = {6{codeBlank}};
		case (mode)
			modeShowTotal: begin
				codes[0] = dec[0];
				codes[1] = dec[1];
				codes[2] = dec[2];
				// Upper digits stay dark when zero.
				codes[3] = (dec[3] == '0) ? codeBlank : dec[3];
				codes[4] = (dec[4] == '0) ? codeBlank : dec[4];
				codes[5] = (dec[5] == '0) ? codeBlank : dec[5];
			end
			modeAdd: begin
				if (promptOn) begin
					codes[0] = digitT'(4'd0);
					codes[1] = digitT'(4'd0);
					codes[2] = codeA;
				end else begin
					codes[0] = shownAmount;
					codes[2] = shownDigits[3:0];
					codes[3] = shownDigits[7:4];
					codes[4] = shownDigits[11:8];
					codes[5] = shownDigits[15:12];
				end
			end
			modeRemove: begin
				if (promptOn) begin
					codes[0] = codeD;
					codes[1] = codeE;
					codes[2] = digitT'(4'd0);
				end else begin
					codes[1] = shownDigits[3:0];
					codes[2] = shownDigits[7:4];
					codes[3] = shownDigits[11:8];
					codes[4] = shownDigits[15:12];
				end
			end
			default: begin
				codes = {6{codeBlank}};
			end
		endcase
	end

endmodule

// ==== shopTerminal.sv ====
module shopTerminal (
	input logic clk,
	input logic rstN,
	input logic switch0,
	input logic switch8,
	input logic switch9,
	input logic button0,
	input logic button1,
	input logic button2,
	input logic button3,
	output logic led0,
	output logic led1,
	output logic led2,
	output logic led3,
	output logic led4,
	output logic led5,
	output logic led8,
	output logic led9,
	output cartPkg::segT hex0,
	output cartPkg::segT hex1,
	output cartPkg::segT hex2,
	output cartPkg::segT hex3,
	output cartPkg::segT hex4,
	output cartPkg::segT hex5
);
	import cartPkg::*;

	modeT mode;
	logic [3:0] buttonsN;
	logic addStrobe;
	logic removeStrobe;
	itemCodeT entryCode;
	amountT entryAmount;
	itemCodeT shownDigits;
	amountT shownAmount;
	totalT cartTotal;
	logic opOk;
	digitT [5:0] codes;
	segT segs [6];

	assign mode = modeT'({switch9, switch8});
	assign buttonsN = {button3, button2, button1, button0};

	assign led0 = switch0;
	assign led1 = opOk;
	assign {led5, led4, led3, led2} = ~buttonsN;
	assign led8 = switch8;
	assign led9 = switch9;

	keyEntry uKeyEntry (
		.clk(clk), .rstN(rstN), .entryEnable(switch0), .mode(mode), .buttonsN(buttonsN),
		.addStrobe(addStrobe), .removeStrobe(removeStrobe),
		.entryCode(entryCode), .entryAmount(entryAmount),
		.shownDigits(shownDigits), .shownAmount(shownAmount)
	);

	cartStore uCartStore (
		.clk(clk), .rstN(rstN), .addStrobe(addStrobe), .removeStrobe(removeStrobe),
		.entryCode(entryCode), .entryAmount(entryAmount),
		.cartTotal(cartTotal), .opOk(opOk)
	);

	cartDisplay uCartDisplay (
		.mode(mode), .shownDigits(shownDigits), .shownAmount(shownAmount),
		.cartTotal(cartTotal), .codes(codes)
	);

	for (genvar g = 0; g < 6; g++) begin : gHex
		sevenSegDecoder uDecoder (.code(codes[g]), .segments(segs[g]));
	end

	assign hex0 = segs[0];
	assign hex1 = segs[1];
	assign hex2 = segs[2];
	assign hex3 = segs[3];
	assign hex4 = segs[4];
	assign hex5 = segs[5];

endmodule

// ==== tbShopTerminal.sv ====
module tbShopTerminal;
	timeunit 1ns;
	timeprecision 1ps;
	import cartPkg::*;

	localparam int clkPeriod = 20;
	localparam int numPresses = 103;
	localparam int watchdogNs = (numPresses * 4 + 200) * clkPeriod;

	logic clk;
	logic rstN;
	logic switch0, switch8, switch9;
	logic button0, button1, button2, button3;
	logic led0, led1, led2, led3, led4, led5, led8, led9;
	segT hex0, hex1, hex2, hex3, hex4, hex5;

	int modelCount [numItems];
	int modelTypes;
	int modelTotal;
	int testErrors;
	int passCount;
	int failCount;

	shopTerminal UUT (
		.clk(clk), .rstN(rstN), .switch0(switch0), .switch8(switch8), .switch9(switch9),
		.button0(button0), .button1(button1), .button2(button2), .button3(button3),
		.led0(led0), .led1(led1), .led2(led2), .led3(led3), .led4(led4), .led5(led5),
		.led8(led8), .led9(led9),
		.hex0(hex0), .hex1(hex1), .hex2(hex2), .hex3(hex3), .hex4(hex4), .hex5(hex5)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(watchdogNs);
		$display("Run timed out after %0d ns, the DUT stopped making progress.", watchdogNs);
		$display("TEST FAIL");
		$finish;
	end

	// Inverse of the segment table. Blank reads back as 4'hB.
	function automatic logic [3:0] decodeSeg(input segT s);
		case (s)
			7'b1000000: return 4'h0;
			7'b1111001: return 4'h1;
			7'b0100100: return 4'h2;
			7'b0110000: return 4'h3;
			7'b0011001: return 4'h4;
			7'b0010010: return 4'h5;
			7'b0000010: return 4'h6;
			7'b1111000: return 4'h7;
			7'b0000000: return 4'h8;
			7'b0010000: return 4'h9;
			7'b0001000: return 4'hA;
			7'b0100001: return 4'hD;
			7'b0000110: return 4'hE;
			7'b1111111: return 4'hB;
			default: return 4'hF;
		endcase
	endfunction

	function automatic segT segAt(input int i);
		case (i)
			0: return hex0;
			1: return hex1;
			2: return hex2;
			3: return hex3;
			4: return hex4;
			default: return hex5;
		endcase
	endfunction

	// Returns -1 when the digits do not form a valid total.
	function automatic int readTotal();
		int value;
		logic [3:0] c;
		value = 0;
		for (int i = 5; i >= 0; i--) begin
			c = decodeSeg(segAt(i));
			if (c == 4'hB && i >= 3)
				c = 4'h0;
			if (c > 4'h9)
				return -1;
			value = value * 10 + c;
		end
		return value;
	endfunction

	// Cart rules applied to the testbench copy of the cart.
	function automatic logic modelOp(input logic isAdd, input logic [15:0] code,
		input int amount);
		int idx;
		idx = -1;
		for (int i = 0; i < numItems; i++) begin
			if (itemCodes[i] == code)
				idx = i;
		end
		if (idx < 0)
			return 1'b0;
		if (isAdd) begin
			if (amount == 0 || modelTypes >= 6 || modelCount[idx] + amount > 4)
				return 1'b0;
			if (modelCount[idx] == 0)
				modelTypes++;
			modelCount[idx] += amount;
			modelTotal += amount * itemPrices[idx];
			return 1'b1;
		end
		if (modelCount[idx] == 0)
			return 1'b0;
		modelTotal -= modelCount[idx] * itemPrices[idx];
		modelCount[idx] = 0;
		modelTypes--;
		return 1'b1;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
			testErrors++;
		end
	endtask

	// Codes packed digit5 down to digit0.
	task automatic checkDisplay(input logic [23:0] expCodes);
		for (int i = 0; i < 6; i++)
			checkValue($sformatf("hex%0d", i), expCodes[i*4 +: 4], decodeSeg(segAt(i)));
	endtask

	// Switch LEDs follow the switches and button LEDs light while held.
	task automatic compareLeds(input logic [3:0] pressedMask);
		checkValue("led0", switch0, led0);
		checkValue("led8", switch8, led8);
		checkValue("led9", switch9, led9);
		checkValue("led5..led2", pressedMask, {led5, led4, led3, led2});
	endtask

	task automatic endTest(input string name);
		if (testErrors == 0) begin
			passCount++;
			$display("Test %s passed", name);
		end else begin
			failCount++;
			$display("Test %s failed with %0d mismatches", name, testErrors);
		end
		testErrors = 0;
	endtask

	task automatic doReset();
		@(posedge clk);
		rstN <= 1'b0;
		{button3, button2, button1, button0} <= 4'hF;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < numItems; i++)
			modelCount[i] = 0;
		modelTypes = 0;
		modelTotal = 0;
	endtask

	task automatic setMode(input modeT m);
		@(posedge clk);
		{switch9, switch8} <= m;
	endtask

	// The caller's next rising edge supplies the second release cycle.
	task automatic pressButtons(input logic [3:0] mask);
		@(posedge clk);
		{button3, button2, button1, button0} <= ~mask;
		@(negedge clk);
		compareLeds(mask);
		repeat (2) @(posedge clk);
		{button3, button2, button1, button0} <= 4'hF;
		@(posedge clk);
	endtask

	// Digit 4 sits on button0 and digit 1 on button3.
	task automatic pressDigit(input int digit);
		pressButtons(4'b0001 << (4 - digit));
	endtask

	task automatic runOp(input logic isAdd, input logic [15:0] code, input int amount);
		logic expOk;
		setMode(isAdd ? modeAdd : modeRemove);
		for (int i = 3; i >= 0; i--)
			pressDigit(code[i*4 +: 4]);
		if (isAdd)
			pressDigit(amount);
		@(negedge clk);
		if (isAdd)
			checkDisplay({code, 4'hB, 4'(amount)});
		else
			checkDisplay({4'hB, code, 4'hB});
		pressDigit(4);
		expOk = modelOp(isAdd, code, amount);
		repeat (3) @(posedge clk);
		setMode(modeShowTotal);
		@(negedge clk);
		checkValue("total", modelTotal, readTotal());
		checkValue("led1", expOk, led1);
	endtask

	initial begin
		int idx;
		int amount;
		bit used [numItems];
		logic [15:0] code;
		rstN = 1'b0;
		switch0 = 1'b1;
		{switch9, switch8} = modeShowTotal;
		{button3, button2, button1, button0} = 4'hF;
		testErrors = 0;
		passCount = 0;
		failCount = 0;
		void'($urandom(76413));
		doReset();

		setMode(modeShowTotal);
		@(negedge clk);
		checkDisplay(24'hBBB000);
		checkValue("led1", 0, led1);
		compareLeds(4'h0);
		setMode(modeAdd);
		@(negedge clk);
		checkDisplay(24'hBBBA00);
		compareLeds(4'h0);
		setMode(modeRemove);
		@(negedge clk);
		checkDisplay(24'hBBB0ED);
		compareLeds(4'h0);
		setMode(modeBlank);
		@(posedge clk);
		switch0 <= 1'b0;
		@(negedge clk);
		checkDisplay(24'hBBBBBB);
		compareLeds(4'h0);
		@(posedge clk);
		switch0 <= 1'b1;
		endTest("reset");

		doReset();
		for (int i = 0; i < numItems; i++)
			used[i] = 1'b0;
		for (int n = 0; n < 3; n++) begin
			do idx = $urandom_range(numItems - 1, 0); while (used[idx]);
			used[idx] = 1'b1;
			runOp(1'b1, itemCodes[idx], $urandom_range(4, 1));
			checkValue("led1 on valid add", 1, led1);
		end
		endTest("valid add");

		doReset();
		idx = $urandom_range(numItems - 1, 0);
		amount = $urandom_range(4, 1);
		runOp(1'b1, itemCodes[idx], amount);
		// Brings the unit count to exactly five.
		runOp(1'b1, itemCodes[idx], 5 - amount);
		checkValue("led1 on over-limit add", 0, led1);
		endTest("over-limit add");

		doReset();
		runOp(1'b1, 16'h4321, 1);
		checkValue("led1 on unknown code", 0, led1);
		for (int i = 0; i < 6; i++)
			runOp(1'b1, itemCodes[i], $urandom_range(4, 1));
		runOp(1'b1, itemCodes[6], 1);
		checkValue("led1 on seventh type", 0, led1);
		endTest("type limit and unknown code");

		doReset();
		idx = $urandom_range(numItems - 1, 0);
		runOp(1'b1, itemCodes[idx], $urandom_range(4, 1));
		runOp(1'b0, itemCodes[idx], 0);
		checkValue("led1 on remove", 1, led1);
		runOp(1'b0, itemCodes[idx], 0);
		checkValue("led1 on second remove", 0, led1);
		endTest("remove");

		doReset();
		code = itemCodes[$urandom_range(numItems - 1, 0)];
		setMode(modeAdd);
		pressDigit(code[15:12]);
		pressDigit(code[11:8]);
		pressButtons(4'b1100);
		@(negedge clk);
		checkDisplay(24'hBBBA00);
		runOp(1'b1, code, $urandom_range(4, 1));
		endTest("clear");

		$display("Tests passed: %0d, tests failed: %0d", passCount, failCount);
		if (failCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== compile.f ====
cartPkg.sv
sevenSegDecoder.sv
keyEntry.sv
cartStore.sv
cartDisplay.sv
shopTerminal.sv
tbShopTerminal.sv
